// ==== Makefile ====
# Verilator flow for the execute stage

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f ex_core.f --top-module ex_core

sim:
	verilator --binary --timing --assert -f ex_core.f --top-module ex_core_tb \
		-Mdir obj_dir -o ex_core_tb
	./obj_dir/ex_core_tb | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/ex_core_tb.sv ====
// directed testbench for the execute stage with register file and reference models
`timescale 1ns/1ps

module ex_core_tb;
  import ex_pkg::*;

  // tests take about 400 cycles
  localparam int max_cycles = 2000;

  logic clk;
  logic rst;
  logic id_valid;
  logic [xlen-1:0] id_pc;
  logic [xlen-1:0] id_imm_op1;
  logic [xlen-1:0] id_imm_op2;
  logic [xlen-1:0] id_jmp_imm;
  logic id_use_rs1;
  logic id_use_rs2;
  logic [4:0] id_rs1_addr;
  logic [4:0] id_rs2_addr;
  logic id_is_word;
  alu_op_e id_alu_op;
  bj_op_e id_bj_op;
  logic id_rd_wr;
  logic [4:0] id_rd_addr;
  logic id_is_load;
  logic id_is_store;
  logic id_allowin;
  logic mem_valid;
  logic [xlen-1:0] mem_pc;
  logic [xlen-1:0] mem_result;
  logic [xlen-1:0] mem_store_data;
  logic mem_rd_wr;
  logic [4:0] mem_rd_addr;
  logic mem_is_load;
  logic mem_is_store;
  logic mem_allowin;
  logic mem_fwd_valid;
  logic [4:0] mem_fwd_addr;
  logic [xlen-1:0] mem_fwd_data;
  logic mem_fwd_is_load;
  logic wb_fwd_valid;
  logic [4:0] wb_fwd_addr;
  logic [xlen-1:0] wb_fwd_data;
  logic [4:0] rs1_addr;
  logic [4:0] rs2_addr;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic bj_valid;
  logic bj_taken;
  logic [xlen-1:0] bj_target;
  logic bj_ready;

  logic [xlen-1:0] regs [0:31];
  int seed = 68988;
  int errors = 0;
  int cycles = 0;

  ex_core dut_i (.*);

  always #50 clk = ~clk;

  // register file model with combinational read
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("timeout: tests did not complete within %0d cycles", max_cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic check(input string name, input logic [xlen-1:0] exp,
                       input logic [xlen-1:0] act);
    assert (exp === act) else begin
      errors = errors + 1;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    assert (exp === act) else begin
      errors = errors + 1;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // riscv integer rules with word form on the low 32 bits then sign extended
  function automatic logic [xlen-1:0] alu_model(input alu_op_e op, input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b, input logic w);
    logic [xlen-1:0] r;
    logic signed [xlen-1:0] sa;
    logic signed [xlen-1:0] sb;
    logic [31:0] x;
    logic signed [31:0] xa;
    logic signed [31:0] xb;
    sa = a;
    sb = b;
    xa = a[31:0];
    xb = b[31:0];
    if (w) begin
      case (op)
        add: x = xa + xb;
        sub: x = xa - xb;
        sll: x = a[31:0] << b[4:0];
        slt: x = (xa < xb) ? 32'd1 : 32'd0;
        sltu: x = (a[31:0] < b[31:0]) ? 32'd1 : 32'd0;
        xor_op: x = a[31:0] ^ b[31:0];
        srl: x = a[31:0] >> b[4:0];
        sra: x = xa >>> b[4:0];
        or_op: x = a[31:0] | b[31:0];
        and_op: x = a[31:0] & b[31:0];
        default: x = '0;
      endcase
      r = {{32{x[31]}}, x};
    end else begin
      case (op)
        add: r = a + b;
        sub: r = a - b;
        sll: r = a << b[5:0];
        slt: r = (sa < sb) ? 64'd1 : 64'd0;
        sltu: r = (a < b) ? 64'd1 : 64'd0;
        xor_op: r = a ^ b;
        srl: r = a >> b[5:0];
        sra: r = sa >>> b[5:0];
        or_op: r = a | b;
        and_op: r = a & b;
        default: r = '0;
      endcase
    end
    return r;
  endfunction

  function automatic logic taken_model(input bj_op_e op, input logic [xlen-1:0] a,
                                       input logic [xlen-1:0] b);
    logic eq;
    logic ltu;
    logic lts;
    eq = (a == b);
    ltu = (a < b);
    // signed order matches unsigned order unless the sign bits differ
    lts = (a[xlen-1] != b[xlen-1]) ? a[xlen-1] : ltu;
    case (op)
      beq: return eq;
      bne: return !eq;
      blt: return lts;
      bge: return !lts;
      bltu: return ltu;
      bgeu: return !ltu;
      jal, jalr: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic drive(input id_to_ex_t ins);
    @(posedge clk);
    id_valid <= 1'b1;
    id_pc <= ins.pc;
    id_imm_op1 <= ins.imm_op1;
    id_imm_op2 <= ins.imm_op2;
    id_jmp_imm <= ins.jmp_imm;
    id_use_rs1 <= ins.use_rs1;
    id_use_rs2 <= ins.use_rs2;
    id_rs1_addr <= ins.rs1_addr;
    id_rs2_addr <= ins.rs2_addr;
    id_is_word <= ins.is_word;
    id_alu_op <= ins.alu_op;
    id_bj_op <= ins.bj_op;
    id_rd_wr <= ins.rd_wr;
    id_rd_addr <= ins.rd_addr;
    id_is_load <= ins.is_load;
    id_is_store <= ins.is_store;
  endtask

  // returns just after the edge that takes the instruction
  task automatic issue(input id_to_ex_t ins);
    drive(ins);
    @(negedge clk);
    while (!id_allowin) @(negedge clk);
    @(posedge clk);
    id_valid <= 1'b0;
  endtask

  task automatic wait_mem();
    @(negedge clk);
    while (!mem_valid) @(negedge clk);
  endtask

  task automatic set_bypass(input logic mv, input logic [4:0] ma, input logic [xlen-1:0] md,
                            input logic ml, input logic wv, input logic [4:0] wa,
                            input logic [xlen-1:0] wd);
    @(posedge clk);
    mem_fwd_valid <= mv;
    mem_fwd_addr <= ma;
    mem_fwd_data <= md;
    mem_fwd_is_load <= ml;
    wb_fwd_valid <= wv;
    wb_fwd_addr <= wa;
    wb_fwd_data <= wd;
  endtask

  task automatic check_reset_state();
    @(negedge clk);
    check_bit("reset mem_valid", 1'b0, mem_valid);
    check_bit("reset bj_valid", 1'b0, bj_valid);
    check_bit("reset id_allowin", 1'b1, id_allowin);
  endtask

  task automatic test_alu();
    id_to_ex_t ins;
    alu_op_e op;
    logic [31:0] rnd;
    string name;
    op = op.first();
    repeat (10) begin
      for (int w = 0; w < 2; w++) begin
        rnd = $random(seed);
        ins = '0;
        ins.pc = {$random(seed), $random(seed)};
        ins.imm_op1 = {$random(seed), $random(seed)};
        ins.imm_op2 = {$random(seed), $random(seed)};
        ins.is_word = (w == 1);
        ins.alu_op = op;
        ins.rd_wr = rnd[5];
        ins.rd_addr = rnd[4:0];
        ins.is_load = rnd[6];
        ins.is_store = rnd[7];
        name = $sformatf("alu %s word=%0d", op.name(), w);
        issue(ins);
        wait_mem();
        check(name, alu_model(op, ins.imm_op1, ins.imm_op2, ins.is_word), mem_result);
        check({name, " pc"}, ins.pc, mem_pc);
        check_bit({name, " rd_wr"}, ins.rd_wr, mem_rd_wr);
        check({name, " rd_addr"}, 64'(ins.rd_addr), 64'(mem_rd_addr));
        check_bit({name, " is_load"}, ins.is_load, mem_is_load);
        check_bit({name, " is_store"}, ins.is_store, mem_is_store);
        check_bit({name, " bj_valid"}, 1'b0, bj_valid);
      end
      op = op.next();
    end
  endtask

  // both sources read the same register so add doubles it
  task automatic fwd_case(input string name, input logic [4:0] addr,
                          input logic [xlen-1:0] exp);
    id_to_ex_t ins;
    ins = '0;
    ins.pc = 64'h2000;
    ins.use_rs1 = 1'b1;
    ins.use_rs2 = 1'b1;
    ins.rs1_addr = addr;
    ins.rs2_addr = addr;
    ins.alu_op = add;
    ins.rd_wr = 1'b1;
    ins.rd_addr = 5'd20;
    issue(ins);
    wait_mem();
    check({name, " result"}, exp + exp, mem_result);
    check({name, " store_data"}, exp, mem_store_data);
  endtask

  task automatic test_forwarding();
    logic [xlen-1:0] md;
    logic [xlen-1:0] wd;
    md = {$random(seed), $random(seed)};
    wd = {$random(seed), $random(seed)};
    set_bypass(1'b0, 5'd0, 64'd0, 1'b0, 1'b0, 5'd0, 64'd0);
    fwd_case("fwd regfile", 5'd9, regs[9]);
    set_bypass(1'b0, 5'd0, 64'd0, 1'b0, 1'b1, 5'd9, wd);
    fwd_case("fwd wb", 5'd9, wd);
    set_bypass(1'b1, 5'd9, md, 1'b0, 1'b1, 5'd9, wd);
    fwd_case("fwd mem over wb", 5'd9, md);
    set_bypass(1'b1, 5'd0, md, 1'b0, 1'b1, 5'd0, wd);
    fwd_case("fwd x0", 5'd0, 64'd0);
    set_bypass(1'b0, 5'd0, 64'd0, 1'b0, 1'b0, 5'd0, 64'd0);
  endtask

  task automatic test_load_use();
    id_to_ex_t ins;
    logic [xlen-1:0] ld;
    ld = {$random(seed), $random(seed)};
    // load to x12 still in mem with its data not there yet
    set_bypass(1'b1, 5'd12, 64'hdead_beef_dead_beef, 1'b1, 1'b0, 5'd0, 64'd0);
    ins = '0;
    ins.pc = 64'h3000;
    ins.use_rs1 = 1'b1;
    ins.rs1_addr = 5'd12;
    ins.imm_op2 = 64'd100;
    ins.alu_op = add;
    ins.rd_wr = 1'b1;
    ins.rd_addr = 5'd13;
    issue(ins);
    repeat (4) begin
      @(negedge clk);
      check_bit("load use mem_valid", 1'b0, mem_valid);
      check_bit("load use id_allowin", 1'b0, id_allowin);
    end
    set_bypass(1'b0, 5'd0, 64'd0, 1'b0, 1'b1, 5'd12, ld);
    wait_mem();
    check("load use result", ld + 64'd100, mem_result);
    set_bypass(1'b0, 5'd0, 64'd0, 1'b0, 1'b0, 5'd0, 64'd0);
  endtask

  task automatic run_branch(input bj_op_e bop, input logic [xlen-1:0] a,
                            input logic [xlen-1:0] b);
    id_to_ex_t ins;
    logic exp_taken;
    logic [xlen-1:0] exp_target;
    string name;
    @(posedge clk);
    regs[1] <= a;
    regs[2] <= b;
    bj_ready <= 1'b0;
    ins = '0;
    ins.pc = 64'h8000;
    ins.jmp_imm = 64'h40;
    ins.use_rs1 = 1'b1;
    ins.use_rs2 = 1'b1;
    ins.rs1_addr = 5'd1;
    ins.rs2_addr = 5'd2;
    ins.bj_op = bop;
    ins.rd_wr = (bop == jal || bop == jalr);
    ins.rd_addr = 5'd1;
    name = $sformatf("branch %s %0h/%0h", bop.name(), a, b);
    exp_taken = taken_model(bop, a, b);
    exp_target = (bop == jalr) ? ((a + ins.jmp_imm) & ~64'd1) : ins.pc + ins.jmp_imm;
    issue(ins);
    // redirect held while fetch is not ready
    repeat (3) begin
      @(negedge clk);
      check_bit({name, " bj_valid"}, 1'b1, bj_valid);
      check_bit({name, " mem_valid"}, 1'b0, mem_valid);
    end
    check_bit({name, " taken"}, exp_taken, bj_taken);
    if (exp_taken)
      check({name, " target"}, exp_target, bj_target);
    @(posedge clk);
    bj_ready <= 1'b1;
    @(negedge clk);
    check_bit({name, " mem_valid"}, 1'b1, mem_valid);
    check({name, " store_data"}, b, mem_store_data);
    if (bop == jal || bop == jalr)
      check({name, " link"}, ins.pc + 64'd4, mem_result);
  endtask

  task automatic test_branches();
    bj_op_e bop;
    bop = beq;
    repeat (8) begin
      run_branch(bop, 64'd5, 64'd5);
      run_branch(bop, 64'd5, 64'd7);
      // negative when signed and huge when unsigned
      run_branch(bop, 64'hffff_ffff_ffff_fffd, 64'd2);
      bop = bop.next();
    end
  endtask

  task automatic test_back_pressure();
    id_to_ex_t ia;
    id_to_ex_t ib;
    ia = '0;
    ia.pc = 64'h9000;
    ia.imm_op1 = 64'd1000;
    ia.imm_op2 = 64'd234;
    ia.alu_op = add;
    ib = '0;
    ib.pc = 64'h9004;
    ib.imm_op1 = 64'hf0f0;
    ib.imm_op2 = 64'h0ff0;
    ib.alu_op = xor_op;
    @(posedge clk);
    mem_allowin <= 1'b0;
    issue(ia);
    drive(ib);
    repeat (4) begin
      @(negedge clk);
      check_bit("stall id_allowin", 1'b0, id_allowin);
      check_bit("stall mem_valid", 1'b1, mem_valid);
      check("stall first result", 64'd1234, mem_result);
      check("stall first pc", 64'h9000, mem_pc);
    end
    @(posedge clk);
    mem_allowin <= 1'b1;
    @(negedge clk);
    check_bit("release id_allowin", 1'b1, id_allowin);
    check("release first result", 64'd1234, mem_result);
    @(posedge clk);
    id_valid <= 1'b0;
    @(negedge clk);
    check_bit("second mem_valid", 1'b1, mem_valid);
    check("second result", 64'hff00, mem_result);
    check("second pc", 64'h9004, mem_pc);
  endtask

  initial begin
    clk = 1'b0;
    rst <= 1'b1;
    id_valid <= 1'b0;
    id_pc <= '0;
    id_imm_op1 <= '0;
    id_imm_op2 <= '0;
    id_jmp_imm <= '0;
    id_use_rs1 <= 1'b0;
    id_use_rs2 <= 1'b0;
    id_rs1_addr <= '0;
    id_rs2_addr <= '0;
    id_is_word <= 1'b0;
    id_alu_op <= add;
    id_bj_op <= bj_none;
    id_rd_wr <= 1'b0;
    id_rd_addr <= '0;
    id_is_load <= 1'b0;
    id_is_store <= 1'b0;
    mem_allowin <= 1'b1;
    bj_ready <= 1'b1;
    mem_fwd_valid <= 1'b0;
    mem_fwd_addr <= '0;
    mem_fwd_data <= '0;
    mem_fwd_is_load <= 1'b0;
    wb_fwd_valid <= 1'b0;
    wb_fwd_addr <= '0;
    wb_fwd_data <= '0;
    for (int i = 0; i < 32; i++) begin
      regs[i[4:0]] <= (i == 0) ? 64'd0 : {$random(seed), $random(seed)};
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    check_reset_state();
    test_alu();
    test_forwarding();
    test_load_use();
    test_branches();
    test_back_pressure();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== ex_core.f ====
logic/ex_pkg.sv
logic/bypass_if.sv
logic/ex_forward.sv
logic/ex_alu.sv
logic/ex_branch.sv
logic/ex_stage.sv
logic/ex_core.sv
dv/ex_core_tb.sv

// ==== logic/bypass_if.sv ====
// bypass bus carrying a later stage's pending register write to forwarding
`timescale 1ns/1ps

interface bypass_if;
  import ex_pkg::*;

  logic            valid;
  logic [4:0]      rd_addr;
  logic [xlen-1:0] data;
  // result not final yet, data arrives a stage later
  logic            is_load;

  modport src (
    output valid, rd_addr, data, is_load
  );

  modport dst (
    input valid, rd_addr, data, is_load
  );

endinterface

// ==== logic/ex_alu.sv ====
// integer alu for full width and 32-bit word operations
`timescale 1ns/1ps

module ex_alu (
  input  logic [ex_pkg::xlen-1:0] op1,
  input  logic [ex_pkg::xlen-1:0] op2,
  input  logic                    is_word,
  input  ex_pkg::alu_op_e         alu_op,
  output logic [ex_pkg::xlen-1:0] result
);
  import ex_pkg::*;

  logic [xlen-1:0] full_res;
  logic [31:0]     word_res;
  logic [31:0]     w1;
  logic [31:0]     w2;
  logic [5:0]      shamt;
  logic [4:0]      shamt_w;

  assign w1      = op1[31:0];
  assign w2      = op2[31:0];
  assign shamt   = op2[5:0];
  assign shamt_w = op2[4:0];

  always_comb begin
    case (alu_op)
      add:     full_res = op1 + op2;
      sub:     full_res = op1 - op2;
      sll:     full_res = op1 << shamt;
      slt:     full_res = {{(xlen-1){1'b0}}, $signed(op1) < $signed(op2)};
      sltu:    full_res = {{(xlen-1){1'b0}}, op1 < op2};
      xor_op:  full_res = op1 ^ op2;
      srl:     full_res = op1 >> shamt;
      sra:     full_res = $signed(op1) >>> shamt;
      or_op:   full_res = op1 | op2;
      and_op:  full_res = op1 & op2;
      default: full_res = '0;
    endcase
  end

  // word form works on the low half only
  always_comb begin
    case (alu_op)
      add:     word_res = w1 + w2;
      sub:     word_res = w1 - w2;
      sll:     word_res = w1 << shamt_w;
      slt:     word_res = {31'b0, $signed(w1) < $signed(w2)};
      sltu:    word_res = {31'b0, w1 < w2};
      xor_op:  word_res = w1 ^ w2;
      srl:     word_res = w1 >> shamt_w;
      sra:     word_res = $signed(w1) >>> shamt_w;
      or_op:   word_res = w1 | w2;
      and_op:  word_res = w1 & w2;
      default: word_res = '0;
    endcase
  end

  // sign extend word results from bit 31
  assign result = is_word ? {{(xlen-32){word_res[31]}}, word_res} : full_res;

endmodule

// ==== logic/ex_branch.sv ====
// branch condition evaluation and redirect target for branches and jumps
`timescale 1ns/1ps

module ex_branch (
  input  ex_pkg::bj_op_e          bj_op,
  input  logic [ex_pkg::xlen-1:0] rs1_value,
  input  logic [ex_pkg::xlen-1:0] rs2_value,
  input  logic [ex_pkg::xlen-1:0] pc,
  input  logic [ex_pkg::xlen-1:0] jmp_imm,
  output logic                    taken,
  output logic [ex_pkg::xlen-1:0] target
);
  import ex_pkg::*;

  logic [xlen-1:0] jalr_sum;

  always_comb begin
    case (bj_op)
      beq:       taken = rs1_value == rs2_value;
      bne:       taken = rs1_value != rs2_value;
      blt:       taken = $signed(rs1_value) < $signed(rs2_value);
      bge:       taken = $signed(rs1_value) >= $signed(rs2_value);
      bltu:      taken = rs1_value < rs2_value;
      bgeu:      taken = rs1_value >= rs2_value;
      jal, jalr: taken = 1'b1;
      default:   taken = 1'b0;
    endcase
  end

  assign jalr_sum = rs1_value + jmp_imm;

  // jalr clears bit 0, everything else is pc relative
  assign target = (bj_op == jalr) ? {jalr_sum[xlen-1:1], 1'b0} : pc + jmp_imm;

endmodule

// ==== logic/ex_core.sv ====
// execute stage top level, packs plain ports into buses and bypass interfaces
`timescale 1ns/1ps

module ex_core (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    id_valid,
  input  logic [ex_pkg::xlen-1:0] id_pc,
  input  logic [ex_pkg::xlen-1:0] id_imm_op1,
  input  logic [ex_pkg::xlen-1:0] id_imm_op2,
  input  logic [ex_pkg::xlen-1:0] id_jmp_imm,
  input  logic                    id_use_rs1,
  input  logic                    id_use_rs2,
  input  logic [4:0]              id_rs1_addr,
  input  logic [4:0]              id_rs2_addr,
  input  logic                    id_is_word,
  input  ex_pkg::alu_op_e         id_alu_op,
  input  ex_pkg::bj_op_e          id_bj_op,
  input  logic                    id_rd_wr,
  input  logic [4:0]              id_rd_addr,
  input  logic                    id_is_load,
  input  logic                    id_is_store,
  output logic                    id_allowin,
  output logic                    mem_valid,
  output logic [ex_pkg::xlen-1:0] mem_pc,
  output logic [ex_pkg::xlen-1:0] mem_result,
  output logic [ex_pkg::xlen-1:0] mem_store_data,
  output logic                    mem_rd_wr,
  output logic [4:0]              mem_rd_addr,
  output logic                    mem_is_load,
  output logic                    mem_is_store,
  input  logic                    mem_allowin,
  input  logic                    mem_fwd_valid,
  input  logic [4:0]              mem_fwd_addr,
  input  logic [ex_pkg::xlen-1:0] mem_fwd_data,
  input  logic                    mem_fwd_is_load,
  input  logic                    wb_fwd_valid,
  input  logic [4:0]              wb_fwd_addr,
  input  logic [ex_pkg::xlen-1:0] wb_fwd_data,
  output logic [4:0]              rs1_addr,
  output logic [4:0]              rs2_addr,
  input  logic [ex_pkg::xlen-1:0] rs1_data,
  input  logic [ex_pkg::xlen-1:0] rs2_data,
  output logic                    bj_valid,
  output logic                    bj_taken,
  output logic [ex_pkg::xlen-1:0] bj_target,
  input  logic                    bj_ready
);
  import ex_pkg::*;

  id_to_ex_t  id_bus;
  ex_to_mem_t mem_bus;

  bypass_if mem_fwd_if ();
  bypass_if wb_fwd_if ();

  assign id_bus = '{
    pc:       id_pc,
    imm_op1:  id_imm_op1,
    imm_op2:  id_imm_op2,
    jmp_imm:  id_jmp_imm,
    use_rs1:  id_use_rs1,
    use_rs2:  id_use_rs2,
    rs1_addr: id_rs1_addr,
    rs2_addr: id_rs2_addr,
    is_word:  id_is_word,
    alu_op:   id_alu_op,
    bj_op:    id_bj_op,
    rd_wr:    id_rd_wr,
    rd_addr:  id_rd_addr,
    is_load:  id_is_load,
    is_store: id_is_store
  };

  assign mem_fwd_if.valid   = mem_fwd_valid;
  assign mem_fwd_if.rd_addr = mem_fwd_addr;
  assign mem_fwd_if.data    = mem_fwd_data;
  assign mem_fwd_if.is_load = mem_fwd_is_load;

  // wb result is always final
  assign wb_fwd_if.valid    = wb_fwd_valid;
  assign wb_fwd_if.rd_addr  = wb_fwd_addr;
  assign wb_fwd_if.data     = wb_fwd_data;
  assign wb_fwd_if.is_load  = 1'b0;

  ex_stage stage_i (
    .clk         (clk),
    .rst         (rst),
    .id_valid    (id_valid),
    .id_bus      (id_bus),
    .id_allowin  (id_allowin),
    .mem_valid   (mem_valid),
    .mem_bus     (mem_bus),
    .mem_allowin (mem_allowin),
    .mem_fwd     (mem_fwd_if.dst),
    .wb_fwd      (wb_fwd_if.dst),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .bj_valid    (bj_valid),
    .bj_taken    (bj_taken),
    .bj_target   (bj_target),
    .bj_ready    (bj_ready)
  );

  assign mem_pc         = mem_bus.pc;
  assign mem_result     = mem_bus.result;
  assign mem_store_data = mem_bus.store_data;
  assign mem_rd_wr      = mem_bus.rd_wr;
  assign mem_rd_addr    = mem_bus.rd_addr;
  assign mem_is_load    = mem_bus.is_load;
  assign mem_is_store   = mem_bus.is_store;

endmodule

// ==== logic/ex_forward.sv ====
// operand forwarding from mem and wb bypasses with load-use hazard detection
`timescale 1ns/1ps

module ex_forward (
  input  logic [4:0]              rs1_addr,
  input  logic [4:0]              rs2_addr,
  input  logic                    use_rs1,
  input  logic                    use_rs2,
  input  logic [ex_pkg::xlen-1:0] rs1_data,
  input  logic [ex_pkg::xlen-1:0] rs2_data,
  bypass_if.dst                   mem_fwd,
  bypass_if.dst                   wb_fwd,
  output logic [ex_pkg::xlen-1:0] rs1_value,
  output logic [ex_pkg::xlen-1:0] rs2_value,
  output logic                    hazard
);
  import ex_pkg::*;

  logic rs1_mem_hit;
  logic rs1_wb_hit;
  logic rs2_mem_hit;
  logic rs2_wb_hit;

  // x0 never matches a bypass
  function automatic logic hit(input logic [4:0] addr, input logic valid,
                               input logic [4:0] src_addr);
    return valid && (addr == src_addr) && (addr != 5'd0);
  endfunction

  // mem bypass wins over wb, wb over register file
  function automatic logic [xlen-1:0] pick(input logic [4:0] addr,
                                           input logic mem_hit, input logic wb_hit,
                                           input logic [xlen-1:0] rf_data);
    if (addr == 5'd0)
      return '0;
    if (mem_hit)
      return mem_fwd.data;
    if (wb_hit)
      return wb_fwd.data;
    return rf_data;
  endfunction

  assign rs1_mem_hit = hit(rs1_addr, mem_fwd.valid, mem_fwd.rd_addr);
  assign rs1_wb_hit  = hit(rs1_addr, wb_fwd.valid, wb_fwd.rd_addr);
  assign rs2_mem_hit = hit(rs2_addr, mem_fwd.valid, mem_fwd.rd_addr);
  assign rs2_wb_hit  = hit(rs2_addr, wb_fwd.valid, wb_fwd.rd_addr);

  assign rs1_value = pick(rs1_addr, rs1_mem_hit, rs1_wb_hit, rs1_data);
  assign rs2_value = pick(rs2_addr, rs2_mem_hit, rs2_wb_hit, rs2_data);

  // load still in mem, its data is not there yet
  assign hazard = mem_fwd.is_load &&
                  ((use_rs1 && rs1_mem_hit) || (use_rs2 && rs2_mem_hit));

endmodule

// ==== logic/ex_pkg.sv ====
// execute stage package with data width, opcode encodings and stage buses
package ex_pkg;

  localparam int xlen = 64;

  // alu opcodes
  typedef enum logic [3:0] {
    add,
    sub,
    sll,
    slt,
    sltu,
    xor_op,
    srl,
    sra,
    or_op,
    and_op
  } alu_op_e;

  // branch and jump opcodes, bj_none for plain alu instructions
  typedef enum logic [3:0] {
    bj_none,
    beq,
    bne,
    blt,
    bge,
    bltu,
    bgeu,
    jal,
    jalr
  } bj_op_e;

  // decoded instruction from decode
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] imm_op1;
    logic [xlen-1:0] imm_op2;
    logic [xlen-1:0] jmp_imm;
    logic            use_rs1;
    logic            use_rs2;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic            is_word;
    alu_op_e         alu_op;
    bj_op_e          bj_op;
    logic            rd_wr;
    logic [4:0]      rd_addr;
    logic            is_load;
    logic            is_store;
  } id_to_ex_t;

  // result handed to the memory stage
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] result;
    logic [xlen-1:0] store_data;
    logic            rd_wr;
    logic [4:0]      rd_addr;
    logic            is_load;
    logic            is_store;
  } ex_to_mem_t;

endpackage

// ==== logic/ex_stage.sv ====
// execute stage register, handshake control, operand select and result assembly
`timescale 1ns/1ps

module ex_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    id_valid,
  input  ex_pkg::id_to_ex_t       id_bus,
  output logic                    id_allowin,
  output logic                    mem_valid,
  output ex_pkg::ex_to_mem_t      mem_bus,
  input  logic                    mem_allowin,
  bypass_if.dst                   mem_fwd,
  bypass_if.dst                   wb_fwd,
  output logic [4:0]              rs1_addr,
  output logic [4:0]              rs2_addr,
  input  logic [ex_pkg::xlen-1:0] rs1_data,
  input  logic [ex_pkg::xlen-1:0] rs2_data,
  output logic                    bj_valid,
  output logic                    bj_taken,
  output logic [ex_pkg::xlen-1:0] bj_target,
  input  logic                    bj_ready
);
  import ex_pkg::*;

  logic            stage_valid;
  id_to_ex_t       inst_r;
  id_to_ex_t       cur;
  logic            is_bj;
  logic            hazard;
  logic            ready_go;
  logic [xlen-1:0] rs1_value;
  logic [xlen-1:0] rs2_value;
  logic [xlen-1:0] op1;
  logic [xlen-1:0] op2;
  logic [xlen-1:0] alu_result;

  // handshake control
  assign is_bj      = cur.bj_op != bj_none;
  assign ready_go   = !hazard && (!is_bj || bj_ready);
  assign mem_valid  = stage_valid && ready_go;
  assign id_allowin = !stage_valid || (ready_go && mem_allowin);

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid <= 1'b0;
    end else if (id_allowin) begin
      stage_valid <= id_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (id_valid && id_allowin) begin
      inst_r <= id_bus;
    end
  end

  // empty stage reads as all zeros, no stale writes or jumps
  assign cur = id_to_ex_t'(inst_r & {$bits(id_to_ex_t){stage_valid}});

  assign rs1_addr = cur.rs1_addr;
  assign rs2_addr = cur.rs2_addr;

  ex_forward forward_i (
    .rs1_addr  (cur.rs1_addr),
    .rs2_addr  (cur.rs2_addr),
    .use_rs1   (cur.use_rs1),
    .use_rs2   (cur.use_rs2),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .mem_fwd   (mem_fwd),
    .wb_fwd    (wb_fwd),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .hazard    (hazard)
  );

  assign op1 = cur.use_rs1 ? rs1_value : cur.imm_op1;
  assign op2 = cur.use_rs2 ? rs2_value : cur.imm_op2;

  ex_alu alu_i (
    .op1     (op1),
    .op2     (op2),
    .is_word (cur.is_word),
    .alu_op  (cur.alu_op),
    .result  (alu_result)
  );

  ex_branch branch_i (
    .bj_op     (cur.bj_op),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .pc        (cur.pc),
    .jmp_imm   (cur.jmp_imm),
    .taken     (bj_taken),
    .target    (bj_target)
  );

  // redirect offered once operands are final
  assign bj_valid = stage_valid && is_bj && !hazard;

  // jumps write the link address
  assign mem_bus.pc         = cur.pc;
  assign mem_bus.result     = (cur.bj_op == jal || cur.bj_op == jalr) ? cur.pc + xlen'(4)
                                                                       : alu_result;
  assign mem_bus.store_data = rs2_value;
  assign mem_bus.rd_wr      = cur.rd_wr;
  assign mem_bus.rd_addr    = cur.rd_addr;
  assign mem_bus.is_load    = cur.is_load;
  assign mem_bus.is_store   = cur.is_store;

endmodule
